// File: Bender.yml
package:
  name: id_stage

export_include_dirs:
  - hdl

sources:
  - hdl/isa_pkg.sv
  - hdl/decode_pkg.sv
  - hdl/decoder_3r.sv
  - hdl/decoder_2ri12.sv
  - hdl/decoder_1ri20.sv
  - hdl/decoder_i26.sv
  - hdl/id_stage.sv
  - target: test
    files:
      - tb/id_stage_asserts.sv
      - tb/id_checker.sv
      - tb/tb_id_stage.sv

// File: hdl/decode_params.svh
`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

// Instruction word width
`define INSTR_W 32

// Program counter width
`define ADDR_W 32

// GPR index width, 32 registers
`define REG_NUM_LOG2 5

// GPR data width, also the decoded immediate width
`define REG_W 32

`endif

// File: hdl/decode_pkg.sv
`include "decode_params.svh"

package decode_pkg;

    typedef logic [`REG_W-1:0] imm_t;

    // Port 1 index in the upper half, port 0 index in the lower half
    typedef logic [2*`REG_NUM_LOG2-1:0] reg_read_addr_t;

    // Exception code from the front end
    typedef logic [3:0] fetch_excp_t;

    typedef logic [7:0] excp_num_t;

    // Positions inside excp_num_t
    localparam int unsigned EXCP_INT       = 0;
    localparam int unsigned EXCP_FETCH_LSB = 1;
    localparam int unsigned EXCP_SYSCALL   = 5;
    localparam int unsigned EXCP_BREAK     = 6;
    localparam int unsigned EXCP_INE       = 7;

endpackage

// File: hdl/decoder_1ri20.sv
`timescale 1ns/1ps

`include "decode_params.svh"

module decoder_1ri20 (
    input  isa_pkg::instr_t   instr_i,
    output logic              valid_o,
    output isa_pkg::aluop_e   aluop_o,
    output isa_pkg::alusel_e  alusel_o,
    output logic              reg_write_valid_o,
    output isa_pkg::reg_idx_t reg_write_addr_o,
    output logic              use_imm_o,
    output decode_pkg::imm_t  imm_o
);
    import isa_pkg::*;

    localparam logic [6:0] OPC_LU12I_W   = 7'h0a;
    localparam logic [6:0] OPC_PCADDU12I = 7'h0e;

    always_comb begin
        valid_o = 1'b1;
        case (instr_i[31:25])
            OPC_LU12I_W:   aluop_o = ALUOP_LU12I_W;
            OPC_PCADDU12I: aluop_o = ALUOP_PCADDU12I;
            default: begin
                valid_o = 1'b0;
                aluop_o = ALUOP_NOP;
            end
        endcase
    end

    assign alusel_o          = valid_o ? ALUSEL_MOVE : ALUSEL_NOP;
    assign reg_write_valid_o = valid_o;
    assign reg_write_addr_o  = valid_o ? instr_i[4:0] : '0;
    assign use_imm_o         = valid_o;
    // si20 placed at bit 12
    assign imm_o = valid_o ? {instr_i[24:5], {(`REG_W-20){1'b0}}} : '0;

endmodule

// File: hdl/decoder_2ri12.sv
`timescale 1ns/1ps

`include "decode_params.svh"

module decoder_2ri12 (
    input  isa_pkg::instr_t            instr_i,
    output logic                       valid_o,
    output isa_pkg::aluop_e            aluop_o,
    output isa_pkg::alusel_e           alusel_o,
    output logic [1:0]                 reg_read_valid_o,
    output decode_pkg::reg_read_addr_t reg_read_addr_o,
    output logic                       reg_write_valid_o,
    output isa_pkg::reg_idx_t          reg_write_addr_o,
    output logic                       use_imm_o,
    output decode_pkg::imm_t           imm_o,
    output logic                       mem_load_o,
    output logic                       mem_store_o
);
    import isa_pkg::*;
    import decode_pkg::*;

    // Opcodes in instr[31:22]
    localparam logic [9:0] OPC_SLTI   = 10'h008;
    localparam logic [9:0] OPC_ADDI_W = 10'h00a;
    localparam logic [9:0] OPC_ANDI   = 10'h00d;
    localparam logic [9:0] OPC_ORI    = 10'h00e;
    localparam logic [9:0] OPC_LD_W   = 10'h0a2;
    localparam logic [9:0] OPC_ST_W   = 10'h0a6;

    reg_idx_t rd;
    reg_idx_t rj;
    imm_t     imm_sext;
    imm_t     imm_zext;
    logic     zext;

    assign rd = instr_i[4:0];
    assign rj = instr_i[9:5];

    assign imm_sext = {{(`REG_W-12){instr_i[21]}}, instr_i[21:10]};
    assign imm_zext = {{(`REG_W-12){1'b0}}, instr_i[21:10]};

    always_comb begin
        valid_o     = 1'b1;
        aluop_o     = ALUOP_NOP;
        alusel_o    = ALUSEL_NOP;
        zext        = 1'b0;
        mem_load_o  = 1'b0;
        mem_store_o = 1'b0;
        case (instr_i[31:22])
            OPC_SLTI: begin
                aluop_o  = ALUOP_SLTI;
                alusel_o = ALUSEL_ARITH;
            end
            OPC_ADDI_W: begin
                aluop_o  = ALUOP_ADDI_W;
                alusel_o = ALUSEL_ARITH;
            end
            // Logic immediates are zero-extended
            OPC_ANDI: begin
                aluop_o  = ALUOP_ANDI;
                alusel_o = ALUSEL_LOGIC;
                zext     = 1'b1;
            end
            OPC_ORI: begin
                aluop_o  = ALUOP_ORI;
                alusel_o = ALUSEL_LOGIC;
                zext     = 1'b1;
            end
            OPC_LD_W: begin
                aluop_o    = ALUOP_LD_W;
                alusel_o   = ALUSEL_LOADSTORE;
                mem_load_o = 1'b1;
            end
            OPC_ST_W: begin
                aluop_o     = ALUOP_ST_W;
                alusel_o    = ALUSEL_LOADSTORE;
                mem_store_o = 1'b1;
            end
            default: begin
                valid_o = 1'b0;
            end
        endcase
    end

    // Store data comes from rd on port 1
    assign reg_read_valid_o  = {mem_store_o, valid_o};
    assign reg_read_addr_o   = valid_o ? {(mem_store_o ? rd : reg_idx_t'(0)), rj} : '0;
    assign reg_write_valid_o = valid_o & ~mem_store_o;
    assign reg_write_addr_o  = reg_write_valid_o ? rd : '0;
    assign use_imm_o         = valid_o;
    assign imm_o             = !valid_o ? '0 : (zext ? imm_zext : imm_sext);

endmodule

// File: hdl/decoder_3r.sv
`timescale 1ns/1ps

`include "decode_params.svh"

module decoder_3r (
    input  isa_pkg::instr_t            instr_i,
    output logic                       valid_o,
    output isa_pkg::aluop_e            aluop_o,
    output isa_pkg::alusel_e           alusel_o,
    output logic [1:0]                 reg_read_valid_o,
    output decode_pkg::reg_read_addr_t reg_read_addr_o,
    output logic                       reg_write_valid_o,
    output isa_pkg::reg_idx_t          reg_write_addr_o,
    output logic                       break_o,
    output logic                       syscall_o
);
    import isa_pkg::*;

    // Opcodes in instr[31:15]
    localparam logic [16:0] OPC_ADD_W   = 17'h00020;
    localparam logic [16:0] OPC_SUB_W   = 17'h00022;
    localparam logic [16:0] OPC_SLT     = 17'h00024;
    localparam logic [16:0] OPC_SLTU    = 17'h00025;
    localparam logic [16:0] OPC_AND     = 17'h00029;
    localparam logic [16:0] OPC_OR      = 17'h0002a;
    localparam logic [16:0] OPC_XOR     = 17'h0002b;
    localparam logic [16:0] OPC_BREAK   = 17'h00054;
    localparam logic [16:0] OPC_SYSCALL = 17'h00056;

    reg_idx_t rd;
    reg_idx_t rj;
    reg_idx_t rk;
    logic     alu_hit;

    assign rd = instr_i[0 +: `REG_NUM_LOG2];
    assign rj = instr_i[5 +: `REG_NUM_LOG2];
    assign rk = instr_i[10 +: `REG_NUM_LOG2];

    always_comb begin
        alu_hit   = 1'b1;
        aluop_o   = ALUOP_NOP;
        alusel_o  = ALUSEL_NOP;
        break_o   = 1'b0;
        syscall_o = 1'b0;
        case (instr_i[31:15])
            OPC_ADD_W: begin
                aluop_o  = ALUOP_ADD_W;
                alusel_o = ALUSEL_ARITH;
            end
            OPC_SUB_W: begin
                aluop_o  = ALUOP_SUB_W;
                alusel_o = ALUSEL_ARITH;
            end
            OPC_SLT: begin
                aluop_o  = ALUOP_SLT;
                alusel_o = ALUSEL_ARITH;
            end
            OPC_SLTU: begin
                aluop_o  = ALUOP_SLTU;
                alusel_o = ALUSEL_ARITH;
            end
            OPC_AND: begin
                aluop_o  = ALUOP_AND;
                alusel_o = ALUSEL_LOGIC;
            end
            OPC_OR: begin
                aluop_o  = ALUOP_OR;
                alusel_o = ALUSEL_LOGIC;
            end
            OPC_XOR: begin
                aluop_o  = ALUOP_XOR;
                alusel_o = ALUSEL_LOGIC;
            end
            // Traps touch no register
            OPC_BREAK: begin
                alu_hit = 1'b0;
                aluop_o = ALUOP_BREAK;
                break_o = 1'b1;
            end
            OPC_SYSCALL: begin
                alu_hit   = 1'b0;
                aluop_o   = ALUOP_SYSCALL;
                syscall_o = 1'b1;
            end
            default: begin
                alu_hit = 1'b0;
            end
        endcase
    end

    assign valid_o = alu_hit | break_o | syscall_o;

    // rj on port 0, rk on port 1, result to rd
    assign reg_read_valid_o  = alu_hit ? 2'b11 : 2'b00;
    assign reg_read_addr_o   = alu_hit ? {rk, rj} : '0;
    assign reg_write_valid_o = alu_hit;
    assign reg_write_addr_o  = alu_hit ? rd : '0;

endmodule

// File: hdl/decoder_i26.sv
`timescale 1ns/1ps

`include "decode_params.svh"

module decoder_i26 (
    input  isa_pkg::instr_t   instr_i,
    output logic              valid_o,
    output isa_pkg::aluop_e   aluop_o,
    output isa_pkg::alusel_e  alusel_o,
    output logic              reg_write_valid_o,
    output isa_pkg::reg_idx_t reg_write_addr_o,
    output logic              use_imm_o,
    output decode_pkg::imm_t  imm_o
);
    import isa_pkg::*;

    localparam logic [5:0] OPC_B  = 6'h14;
    localparam logic [5:0] OPC_BL = 6'h15;

    always_comb begin
        valid_o = 1'b1;
        case (instr_i[31:26])
            OPC_B:  aluop_o = ALUOP_B;
            OPC_BL: aluop_o = ALUOP_BL;
            default: begin
                valid_o = 1'b0;
                aluop_o = ALUOP_NOP;
            end
        endcase
    end

    assign alusel_o = valid_o ? ALUSEL_JUMP : ALUSEL_NOP;

    // BL links into r1
    assign reg_write_valid_o = (aluop_o == ALUOP_BL);
    assign reg_write_addr_o  = reg_write_valid_o ? reg_idx_t'(1) : '0;
    assign use_imm_o         = valid_o;

    // offs26 = {instr[9:0], instr[25:10]}, word offset
    assign imm_o = valid_o ?
        {{(`REG_W-28){instr_i[9]}}, instr_i[9:0], instr_i[25:10], 2'b00} : '0;

endmodule

// File: hdl/id_stage.sv
`timescale 1ns/1ps

module id_stage (
    input  logic                       clk,
    input  logic                       rst_n_i,
    // Instruction buffer side
    input  logic                       ib_valid_i,
    output logic                       ib_ready_o,
    input  isa_pkg::addr_t             ib_pc_i,
    input  isa_pkg::instr_t            ib_instr_i,
    input  logic                       ib_excp_i,
    input  decode_pkg::fetch_excp_t    ib_excp_num_i,
    input  logic                       has_int_i,
    // Dispatch side
    output logic                       ds_valid_o,
    input  logic                       ds_ready_i,
    output isa_pkg::addr_t             ds_pc_o,
    output isa_pkg::instr_t            ds_instr_o,
    output isa_pkg::aluop_e            ds_aluop_o,
    output isa_pkg::alusel_e           ds_alusel_o,
    output logic [1:0]                 ds_reg_read_valid_o,
    output decode_pkg::reg_read_addr_t ds_reg_read_addr_o,
    output logic                       ds_reg_write_valid_o,
    output isa_pkg::reg_idx_t          ds_reg_write_addr_o,
    output logic                       ds_use_imm_o,
    output decode_pkg::imm_t           ds_imm_o,
    output logic                       ds_mem_load_o,
    output logic                       ds_mem_store_o,
    output logic                       ds_excp_o,
    output decode_pkg::excp_num_t      ds_excp_num_o
);
    import isa_pkg::*;
    import decode_pkg::*;

    // 3R results
    logic           r3_valid;
    aluop_e         r3_aluop;
    alusel_e        r3_alusel;
    logic [1:0]     r3_rd_valid;
    reg_read_addr_t r3_rd_addr;
    logic           r3_wr_valid;
    reg_idx_t       r3_wr_addr;
    logic           r3_break;
    logic           r3_syscall;

    // 2RI12 results
    logic           i12_valid;
    aluop_e         i12_aluop;
    alusel_e        i12_alusel;
    logic [1:0]     i12_rd_valid;
    reg_read_addr_t i12_rd_addr;
    logic           i12_wr_valid;
    reg_idx_t       i12_wr_addr;
    logic           i12_use_imm;
    imm_t           i12_imm;
    logic           i12_load;
    logic           i12_store;

    // 1RI20 results
    logic           i20_valid;
    aluop_e         i20_aluop;
    alusel_e        i20_alusel;
    logic           i20_wr_valid;
    reg_idx_t       i20_wr_addr;
    logic           i20_use_imm;
    imm_t           i20_imm;

    // I26 results
    logic           i26_valid;
    aluop_e         i26_aluop;
    alusel_e        i26_alusel;
    logic           i26_wr_valid;
    reg_idx_t       i26_wr_addr;
    logic           i26_use_imm;
    imm_t           i26_imm;

    logic           accept;
    logic           excp_ine;
    excp_num_t      excp_num_d;

    decoder_3r u_decoder_3r (
        .instr_i           (ib_instr_i),
        .valid_o           (r3_valid),
        .aluop_o           (r3_aluop),
        .alusel_o          (r3_alusel),
        .reg_read_valid_o  (r3_rd_valid),
        .reg_read_addr_o   (r3_rd_addr),
        .reg_write_valid_o (r3_wr_valid),
        .reg_write_addr_o  (r3_wr_addr),
        .break_o           (r3_break),
        .syscall_o         (r3_syscall)
    );

    decoder_2ri12 u_decoder_2ri12 (
        .instr_i           (ib_instr_i),
        .valid_o           (i12_valid),
        .aluop_o           (i12_aluop),
        .alusel_o          (i12_alusel),
        .reg_read_valid_o  (i12_rd_valid),
        .reg_read_addr_o   (i12_rd_addr),
        .reg_write_valid_o (i12_wr_valid),
        .reg_write_addr_o  (i12_wr_addr),
        .use_imm_o         (i12_use_imm),
        .imm_o             (i12_imm),
        .mem_load_o        (i12_load),
        .mem_store_o       (i12_store)
    );

    decoder_1ri20 u_decoder_1ri20 (
        .instr_i           (ib_instr_i),
        .valid_o           (i20_valid),
        .aluop_o           (i20_aluop),
        .alusel_o          (i20_alusel),
        .reg_write_valid_o (i20_wr_valid),
        .reg_write_addr_o  (i20_wr_addr),
        .use_imm_o         (i20_use_imm),
        .imm_o             (i20_imm)
    );

    decoder_i26 u_decoder_i26 (
        .instr_i           (ib_instr_i),
        .valid_o           (i26_valid),
        .aluop_o           (i26_aluop),
        .alusel_o          (i26_alusel),
        .reg_write_valid_o (i26_wr_valid),
        .reg_write_addr_o  (i26_wr_addr),
        .use_imm_o         (i26_use_imm),
        .imm_o             (i26_imm)
    );

    // No group claimed the word
    assign excp_ine = ~(r3_valid | i12_valid | i20_valid | i26_valid);

    always_comb begin
        excp_num_d = '0;
        excp_num_d[EXCP_INT] = has_int_i;
        excp_num_d[EXCP_FETCH_LSB +: $bits(fetch_excp_t)] = ib_excp_num_i;
        excp_num_d[EXCP_SYSCALL] = r3_syscall;
        excp_num_d[EXCP_BREAK] = r3_break;
        excp_num_d[EXCP_INE] = excp_ine;
    end

    // One-entry output register
    assign ib_ready_o = ~ds_valid_o | ds_ready_i;
    assign accept     = ib_valid_i & ib_ready_o;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ds_valid_o <= 1'b0;
        end else if (accept) begin
            ds_valid_o <= 1'b1;
        end else if (ds_ready_i) begin
            ds_valid_o <= 1'b0;
        end
    end

    // Sub-decoders drive zeros unless they match, so OR merges them
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ds_pc_o              <= '0;
            ds_instr_o           <= '0;
            ds_aluop_o           <= ALUOP_NOP;
            ds_alusel_o          <= ALUSEL_NOP;
            ds_reg_read_valid_o  <= '0;
            ds_reg_read_addr_o   <= '0;
            ds_reg_write_valid_o <= 1'b0;
            ds_reg_write_addr_o  <= '0;
            ds_use_imm_o         <= 1'b0;
            ds_imm_o             <= '0;
            ds_mem_load_o        <= 1'b0;
            ds_mem_store_o       <= 1'b0;
            ds_excp_o            <= 1'b0;
            ds_excp_num_o        <= '0;
        end else if (accept) begin
            ds_pc_o              <= ib_pc_i;
            ds_instr_o           <= ib_instr_i;
            ds_aluop_o           <= aluop_e'(r3_aluop | i12_aluop | i20_aluop | i26_aluop);
            ds_alusel_o          <= alusel_e'(r3_alusel | i12_alusel | i20_alusel | i26_alusel);
            ds_reg_read_valid_o  <= r3_rd_valid | i12_rd_valid;
            ds_reg_read_addr_o   <= r3_rd_addr | i12_rd_addr;
            ds_reg_write_valid_o <= r3_wr_valid | i12_wr_valid | i20_wr_valid | i26_wr_valid;
            ds_reg_write_addr_o  <= r3_wr_addr | i12_wr_addr | i20_wr_addr | i26_wr_addr;
            ds_use_imm_o         <= i12_use_imm | i20_use_imm | i26_use_imm;
            ds_imm_o             <= i12_imm | i20_imm | i26_imm;
            ds_mem_load_o        <= i12_load;
            ds_mem_store_o       <= i12_store;
            // Unknown words still go out as a NOP that carries INE
            ds_excp_o            <= (|excp_num_d) | ib_excp_i;
            ds_excp_num_o        <= excp_num_d;
        end
    end

endmodule

// File: hdl/isa_pkg.sv
`include "decode_params.svh"

package isa_pkg;

    typedef logic [`INSTR_W-1:0]      instr_t;
    typedef logic [`ADDR_W-1:0]       addr_t;
    typedef logic [`REG_NUM_LOG2-1:0] reg_idx_t;

    // One code per supported operation, zero means no operation
    typedef enum logic [7:0] {
        ALUOP_NOP       = 8'h00,
        ALUOP_ADD_W     = 8'h01,
        ALUOP_SUB_W     = 8'h02,
        ALUOP_SLT       = 8'h03,
        ALUOP_SLTU      = 8'h04,
        ALUOP_AND       = 8'h05,
        ALUOP_OR        = 8'h06,
        ALUOP_XOR       = 8'h07,
        ALUOP_BREAK     = 8'h08,
        ALUOP_SYSCALL   = 8'h09,
        ALUOP_SLTI      = 8'h0a,
        ALUOP_ADDI_W    = 8'h0b,
        ALUOP_ANDI      = 8'h0c,
        ALUOP_ORI       = 8'h0d,
        ALUOP_LD_W      = 8'h0e,
        ALUOP_ST_W      = 8'h0f,
        ALUOP_LU12I_W   = 8'h10,
        ALUOP_PCADDU12I = 8'h11,
        ALUOP_B         = 8'h12,
        ALUOP_BL        = 8'h13
    } aluop_e;

    // Execution unit class
    typedef enum logic [2:0] {
        ALUSEL_NOP       = 3'd0,
        ALUSEL_ARITH     = 3'd1,
        ALUSEL_LOGIC     = 3'd2,
        ALUSEL_MOVE      = 3'd3,
        ALUSEL_JUMP      = 3'd4,
        ALUSEL_LOADSTORE = 3'd5
    } alusel_e;

endpackage

// File: sim.f
+incdir+hdl
hdl/isa_pkg.sv
hdl/decode_pkg.sv
hdl/decoder_3r.sv
hdl/decoder_2ri12.sv
hdl/decoder_1ri20.sv
hdl/decoder_i26.sv
hdl/id_stage.sv
tb/id_stage_asserts.sv
tb/id_checker.sv
tb/tb_id_stage.sv

// File: tb/id_checker.sv
`timescale 1ns/1ps

`include "decode_params.svh"

module id_checker (
    input logic                       clk,
    input logic                       rst_n_i,
    input logic                       ds_valid_o,
    input logic                       ds_ready_i,
    input isa_pkg::addr_t             ds_pc_o,
    input isa_pkg::instr_t            ds_instr_o,
    input isa_pkg::aluop_e            ds_aluop_o,
    input isa_pkg::alusel_e           ds_alusel_o,
    input logic [1:0]                 ds_reg_read_valid_o,
    input decode_pkg::reg_read_addr_t ds_reg_read_addr_o,
    input logic                       ds_reg_write_valid_o,
    input isa_pkg::reg_idx_t          ds_reg_write_addr_o,
    input logic                       ds_use_imm_o,
    input decode_pkg::imm_t           ds_imm_o,
    input logic                       ds_mem_load_o,
    input logic                       ds_mem_store_o,
    input logic                       ds_excp_o,
    input decode_pkg::excp_num_t      ds_excp_num_o
);
    import isa_pkg::*;
    import decode_pkg::*;

    logic [136:0] exp_q[$];
    int n_pass = 0;
    int n_fail = 0;
    int n_done = 0;

    task automatic push(input logic [136:0] e);
        exp_q.push_back(e);
    endtask

    task automatic check_field(input string name, input logic [31:0] exp,
                               input logic [31:0] act, inout bit ok);
        if (act !== exp) begin
            $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
            ok = 1'b0;
        end
    endtask

    // Compare at every dispatch transfer
    always @(posedge clk) begin
        logic [136:0] e;
        bit ok;
        if (rst_n_i && ds_valid_o && ds_ready_i) begin
            if (exp_q.size() == 0) begin
                $display("Dispatch transfer at %0t with no instruction outstanding", $time);
                n_fail++;
            end else begin
                e  = exp_q.pop_front();
                ok = 1'b1;
                check_field("ds_pc_o", e[136:105], ds_pc_o, ok);
                check_field("ds_instr_o", e[104:73], ds_instr_o, ok);
                check_field("ds_aluop_o", 32'(e[72:65]), 32'(ds_aluop_o), ok);
                check_field("ds_alusel_o", 32'(e[64:62]), 32'(ds_alusel_o), ok);
                check_field("ds_reg_read_valid_o", 32'(e[61:60]), 32'(ds_reg_read_valid_o), ok);
                check_field("ds_reg_read_addr_o", 32'(e[59:50]), 32'(ds_reg_read_addr_o), ok);
                check_field("ds_reg_write_valid_o", 32'(e[49]), 32'(ds_reg_write_valid_o), ok);
                check_field("ds_reg_write_addr_o", 32'(e[48:44]), 32'(ds_reg_write_addr_o), ok);
                check_field("ds_use_imm_o", 32'(e[43]), 32'(ds_use_imm_o), ok);
                check_field("ds_imm_o", e[42:11], ds_imm_o, ok);
                check_field("ds_mem_load_o", 32'(e[10]), 32'(ds_mem_load_o), ok);
                check_field("ds_mem_store_o", 32'(e[9]), 32'(ds_mem_store_o), ok);
                check_field("ds_excp_o", 32'(e[8]), 32'(ds_excp_o), ok);
                check_field("ds_excp_num_o", 32'(e[7:0]), 32'(ds_excp_num_o), ok);
                if (ok) begin
                    n_pass++;
                end else begin
                    n_fail++;
                end
                $display("Test %0d pc=%h instr=%h: %s", n_done, e[136:105], e[104:73],
                         ok ? "ok" : "mismatch");
                n_done++;
            end
        end
    end

endmodule

// File: tb/id_stage_asserts.sv
`timescale 1ns/1ps

module id_stage_asserts (
    input logic        clk,
    input logic        rst_n_i,
    input logic        ib_valid_i,
    input logic        ib_ready_o,
    input logic [31:0] ib_instr_i,
    input logic        ds_valid_o,
    input logic        ds_ready_i,
    input logic [31:0] ds_pc_o,
    input logic [31:0] ds_instr_o,
    input logic [7:0]  ds_aluop_o,
    input logic [2:0]  ds_alusel_o,
    input logic [1:0]  ds_reg_read_valid_o,
    input logic [9:0]  ds_reg_read_addr_o,
    input logic        ds_reg_write_valid_o,
    input logic [4:0]  ds_reg_write_addr_o,
    input logic        ds_use_imm_o,
    input logic [31:0] ds_imm_o,
    input logic        ds_mem_load_o,
    input logic        ds_mem_store_o,
    input logic        ds_excp_o,
    input logic [7:0]  ds_excp_num_o
);
    int n_fail = 0;

    // Every ds_ payload bit
    logic [136:0] ds_payload;

    assign ds_payload = {ds_pc_o, ds_instr_o, ds_aluop_o, ds_alusel_o,
                         ds_reg_read_valid_o, ds_reg_read_addr_o,
                         ds_reg_write_valid_o, ds_reg_write_addr_o,
                         ds_use_imm_o, ds_imm_o, ds_mem_load_o, ds_mem_store_o,
                         ds_excp_o, ds_excp_num_o};

    a_reset_idle: assert property (@(posedge clk) !rst_n_i |-> !ds_valid_o)
        else begin
            $error("ds_valid_o high during reset");
            n_fail++;
        end

    // Stalled output must hold
    a_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        ds_valid_o && !ds_ready_i |=> ds_valid_o && $stable(ds_payload))
        else begin
            $error("ds_ outputs changed while stalled");
            n_fail++;
        end

    a_ready_rule: assert property (@(posedge clk) disable iff (!rst_n_i)
        ib_ready_o == (!ds_valid_o || ds_ready_i))
        else begin
            $error("ib_ready_o breaks the ready rule");
            n_fail++;
        end

    a_excp_flag: assert property (@(posedge clk) disable iff (!rst_n_i)
        (|ds_excp_num_o) |-> ds_excp_o)
        else begin
            $error("ds_excp_o low with exception bits set");
            n_fail++;
        end

    // One cycle from acceptance to dispatch
    a_latency: assert property (@(posedge clk) disable iff (!rst_n_i)
        ib_valid_i && ib_ready_o |=> ds_valid_o && ds_instr_o == $past(ib_instr_i))
        else begin
            $error("accepted instruction not presented next cycle");
            n_fail++;
        end

endmodule

// File: tb/tb_id_stage.sv
`timescale 1ns/1ps

module tb_id_stage;
    import isa_pkg::*;
    import decode_pkg::*;

    localparam int ROWS = 23;
    localparam int CLK_PERIOD = 8;
    localparam int EXP_W = 137;

    logic           clk;
    logic           rst_n_i;
    logic           ib_valid_i;
    logic           ib_ready_o;
    addr_t          ib_pc_i;
    instr_t         ib_instr_i;
    logic           ib_excp_i;
    fetch_excp_t    ib_excp_num_i;
    logic           has_int_i;
    logic           ds_valid_o;
    logic           ds_ready_i;
    addr_t          ds_pc_o;
    instr_t         ds_instr_o;
    aluop_e         ds_aluop_o;
    alusel_e        ds_alusel_o;
    logic [1:0]     ds_reg_read_valid_o;
    reg_read_addr_t ds_reg_read_addr_o;
    logic           ds_reg_write_valid_o;
    reg_idx_t       ds_reg_write_addr_o;
    logic           ds_use_imm_o;
    imm_t           ds_imm_o;
    logic           ds_mem_load_o;
    logic           ds_mem_store_o;
    logic           ds_excp_o;
    excp_num_t      ds_excp_num_o;

    // Stimulus table
    logic [31:0]      in_instr [ROWS];
    logic [31:0]      in_pc [ROWS];
    logic             in_excp [ROWS];
    logic [3:0]       in_excp_num [ROWS];
    logic             in_int [ROWS];
    logic [EXP_W-1:0] exp_vec [ROWS];

    logic [31:0] lfsr;

    id_stage u_id_stage (.*);

    id_checker u_checker (
        .clk                  (clk),
        .rst_n_i              (rst_n_i),
        .ds_valid_o           (ds_valid_o),
        .ds_ready_i           (ds_ready_i),
        .ds_pc_o              (ds_pc_o),
        .ds_instr_o           (ds_instr_o),
        .ds_aluop_o           (ds_aluop_o),
        .ds_alusel_o          (ds_alusel_o),
        .ds_reg_read_valid_o  (ds_reg_read_valid_o),
        .ds_reg_read_addr_o   (ds_reg_read_addr_o),
        .ds_reg_write_valid_o (ds_reg_write_valid_o),
        .ds_reg_write_addr_o  (ds_reg_write_addr_o),
        .ds_use_imm_o         (ds_use_imm_o),
        .ds_imm_o             (ds_imm_o),
        .ds_mem_load_o        (ds_mem_load_o),
        .ds_mem_store_o       (ds_mem_store_o),
        .ds_excp_o            (ds_excp_o),
        .ds_excp_num_o        (ds_excp_num_o)
    );

    bind id_stage id_stage_asserts u_asserts (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        lfsr_step = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR bit per cycle for back-pressure
    always @(posedge clk) begin
        logic [31:0] lfsr_next;
        lfsr_next = lfsr_step(lfsr);
        lfsr       <= lfsr_next;
        ds_ready_i <= lfsr_next[0];
    end

    task automatic set_in(input int i, input logic [31:0] instr, input logic excp,
                          input logic [3:0] num, input logic irq);
        in_instr[i]    = instr;
        in_pc[i]       = 32'h1c00_0000 + 4 * i;
        in_excp[i]     = excp;
        in_excp_num[i] = num;
        in_int[i]      = irq;
    endtask

    task automatic set_exp(input int i, input logic [7:0] op, input logic [2:0] sel,
                           input logic [1:0] rrv, input logic [9:0] rra, input logic rwv,
                           input logic [4:0] rwa, input logic use_imm, input logic [31:0] imm,
                           input logic ld, input logic st, input logic eo,
                           input logic [7:0] en);
        exp_vec[i] = {in_pc[i], in_instr[i], op, sel, rrv, rra, rwv, rwa, use_imm, imm,
                      ld, st, eo, en};
    endtask

    initial begin
        set_in(0, 32'h0010_1483, 0, 4'h0, 0);
        set_in(1, 32'h0011_7c41, 0, 4'h0, 0);
        set_in(2, 32'h0012_2507, 0, 4'h0, 0);
        set_in(3, 32'h0012_b16a, 0, 4'h0, 0);
        set_in(4, 32'h0014_bdcd, 0, 4'h0, 0);
        set_in(5, 32'h0015_4a30, 0, 4'h0, 0);
        set_in(6, 32'h0015_d693, 0, 4'h0, 0);
        set_in(7, 32'h002a_0000, 0, 4'h0, 0);
        set_in(8, 32'h002b_0000, 0, 4'h0, 0);
        set_in(9, 32'h0220_0041, 0, 4'h0, 0);
        set_in(10, 32'h029f_fcc5, 0, 4'h0, 0);
        set_in(11, 32'h037f_fd07, 0, 4'h0, 0);
        set_in(12, 32'h03a2_9549, 0, 4'h0, 0);
        set_in(13, 32'h28bf_f064, 0, 4'h0, 0);
        set_in(14, 32'h2980_40a6, 0, 4'h0, 0);
        set_in(15, 32'h1500_0022, 0, 4'h0, 0);
        set_in(16, 32'h1c24_68bf, 0, 4'h0, 0);
        set_in(17, 32'h53ff_ffff, 0, 4'h0, 0);
        set_in(18, 32'h5404_0000, 0, 4'h0, 0);
        set_in(19, 32'hffff_ffff, 0, 4'h0, 0);
        set_in(20, 32'h0010_1483, 1, 4'ha, 1);
        set_in(21, 32'h0000_0000, 0, 4'h0, 1);
        set_in(22, 32'h03a2_9549, 1, 4'h0, 0);
        // ALU 3R
        set_exp(0, 8'h01, 3'd1, 2'b11, 10'h0a4, 1, 5'd3, 0, 32'h0, 0, 0, 0, 8'h00);
        set_exp(1, 8'h02, 3'd1, 2'b11, 10'h3e2, 1, 5'd1, 0, 32'h0, 0, 0, 0, 8'h00);
        set_exp(2, 8'h03, 3'd1, 2'b11, 10'h128, 1, 5'd7, 0, 32'h0, 0, 0, 0, 8'h00);
        set_exp(3, 8'h04, 3'd1, 2'b11, 10'h18b, 1, 5'd10, 0, 32'h0, 0, 0, 0, 8'h00);
        set_exp(4, 8'h05, 3'd2, 2'b11, 10'h1ee, 1, 5'd13, 0, 32'h0, 0, 0, 0, 8'h00);
        set_exp(5, 8'h06, 3'd2, 2'b11, 10'h251, 1, 5'd16, 0, 32'h0, 0, 0, 0, 8'h00);
        set_exp(6, 8'h07, 3'd2, 2'b11, 10'h2b4, 1, 5'd19, 0, 32'h0, 0, 0, 0, 8'h00);
        // Traps
        set_exp(7, 8'h08, 3'd0, 2'b00, 10'h000, 0, 5'd0, 0, 32'h0, 0, 0, 1, 8'h40);
        set_exp(8, 8'h09, 3'd0, 2'b00, 10'h000, 0, 5'd0, 0, 32'h0, 0, 0, 1, 8'h20);
        // 12-bit immediates
        set_exp(9, 8'h0a, 3'd1, 2'b01, 10'h002, 1, 5'd1, 1, 32'hffff_f800, 0, 0, 0, 8'h00);
        set_exp(10, 8'h0b, 3'd1, 2'b01, 10'h006, 1, 5'd5, 1, 32'h0000_07ff, 0, 0, 0, 8'h00);
        set_exp(11, 8'h0c, 3'd2, 2'b01, 10'h008, 1, 5'd7, 1, 32'h0000_0fff, 0, 0, 0, 8'h00);
        set_exp(12, 8'h0d, 3'd2, 2'b01, 10'h00a, 1, 5'd9, 1, 32'h0000_08a5, 0, 0, 0, 8'h00);
        set_exp(13, 8'h0e, 3'd5, 2'b01, 10'h003, 1, 5'd4, 1, 32'hffff_fffc, 1, 0, 0, 8'h00);
        set_exp(14, 8'h0f, 3'd5, 2'b11, 10'h0c5, 0, 5'd0, 1, 32'h0000_0010, 0, 1, 0, 8'h00);
        // 20-bit immediates and branches
        set_exp(15, 8'h10, 3'd3, 2'b00, 10'h000, 1, 5'd2, 1, 32'h8000_1000, 0, 0, 0, 8'h00);
        set_exp(16, 8'h11, 3'd3, 2'b00, 10'h000, 1, 5'd31, 1, 32'h1234_5000, 0, 0, 0, 8'h00);
        set_exp(17, 8'h12, 3'd4, 2'b00, 10'h000, 0, 5'd0, 1, 32'hffff_fffc, 0, 0, 0, 8'h00);
        set_exp(18, 8'h13, 3'd4, 2'b00, 10'h000, 1, 5'd1, 1, 32'h0000_0400, 0, 0, 0, 8'h00);
        // Exceptions
        set_exp(19, 8'h00, 3'd0, 2'b00, 10'h000, 0, 5'd0, 0, 32'h0, 0, 0, 1, 8'h80);
        set_exp(20, 8'h01, 3'd1, 2'b11, 10'h0a4, 1, 5'd3, 0, 32'h0, 0, 0, 1, 8'h15);
        set_exp(21, 8'h00, 3'd0, 2'b00, 10'h000, 0, 5'd0, 0, 32'h0, 0, 0, 1, 8'h81);
        set_exp(22, 8'h0d, 3'd2, 2'b01, 10'h00a, 1, 5'd9, 1, 32'h0000_08a5, 0, 0, 1, 8'h00);
    end

    initial begin
        clk           = 1'b0;
        rst_n_i       = 1'b0;
        ib_valid_i    = 1'b0;
        ib_pc_i       = '0;
        ib_instr_i    = '0;
        ib_excp_i     = 1'b0;
        ib_excp_num_i = '0;
        has_int_i     = 1'b0;
        ds_ready_i    = 1'b0;
        lfsr          = 32'h421b_31af;
        repeat (10) @(posedge clk);
        rst_n_i <= 1'b1;
        for (int i = 0; i < ROWS; i++) begin
            ib_valid_i    <= 1'b1;
            ib_pc_i       <= in_pc[i];
            ib_instr_i    <= in_instr[i];
            ib_excp_i     <= in_excp[i];
            ib_excp_num_i <= in_excp_num[i];
            has_int_i     <= in_int[i];
            u_checker.push(exp_vec[i]);
            // Hold the row until the stage takes it
            do begin
                @(negedge clk);
            end while (!ib_ready_o);
            @(posedge clk);
        end
        ib_valid_i <= 1'b0;
        wait (u_checker.n_done == ROWS);
        repeat (4) @(posedge clk);
        $display("Tests: %0d passed, %0d failed, %0d assertion failures",
                 u_checker.n_pass, u_checker.n_fail, u_id_stage.u_asserts.n_fail);
        if (u_checker.n_fail == 0 && u_checker.n_pass == ROWS &&
            u_id_stage.u_asserts.n_fail == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(CLK_PERIOD * (ROWS * 8 + 50));
        $display("Timeout: not every row reached dispatch in time");
        $display("*** FAILED ***");
        $finish;
    end

endmodule
